//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the trace monitor testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dbgmon -Mdir obj_dir -f vlog.f \
    && ./obj_dir/Vtb_dbgmon 2>&1 | tee "$LOG" \
    || { echo "build or run error"; exit 1; }

grep -q "Simulation failed" "$LOG" && { echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" "$LOG" || { echo "FAIL: run did not finish"; exit 1; }

echo "PASS"
exit 0

//--- src/dbgmon_apb_pkg.sv
`include "dbgmon_defs.svh"

package dbgmon_apb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // apb bus types
    // ~~~~~~~~~~~~~~~~~~~~

    // byte offset inside the monitor.
    typedef logic [`DBGMON_ADDR_W-1:0] apb_addr_t;

    typedef logic [31:0] apb_data_t;

    // requester to monitor.
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    // monitor to requester.
    typedef struct packed {
        logic      pready;
        logic      pslverr;
        apb_data_t prdata;
    } apb_rsp_t;

endpackage

//--- src/dbgmon_defs.svh
`ifndef DBGMON_DEFS_SVH
`define DBGMON_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// sizes
// ~~~~~~~~~~~~~~~~~~~~

// apb offset width, covers the 4 KB trace window and the register block.
`define DBGMON_ADDR_W     13

// trace ring buffer.
`define DBGMON_DEPTH      128
`define DBGMON_IDX_W      7

// breakpoints and watchpoints each.
`define DBGMON_NUM_MATCH  4

// ~~~~~~~~~~~~~~~~~~~~
// register map
// ~~~~~~~~~~~~~~~~~~~~

// offsets below 13'h1000 are the trace window.
// entry offset in bits 11..5, word in bits 4..2.

// 8 bytes per matcher, low word first.
// high word holds the enable in bit 31.
`define DBGMON_BP_BASE    13'h1000
`define DBGMON_WP_BASE    13'h1020

// cause masks, one bit per cause.
`define DBGMON_EXC        13'h1040
`define DBGMON_IRQ        13'h1044

// packets recorded after the trigger packet.
`define DBGMON_DELAY      13'h1048

// bit 0 reads the stopped flag, writing 0 re-arms.
`define DBGMON_STOP       13'h104C

`endif

//--- src/dbgmon_reg_decode.sv
`include "dbgmon_defs.svh"

module dbgmon_reg_decode (
    input  logic                        clk,
    input  logic                        rstn,
    input  dbgmon_apb_pkg::apb_req_t    apb_req,
    output dbgmon_apb_pkg::apb_rsp_t    apb_rsp,
    input  logic                        stopped,
    input  dbgmon_apb_pkg::apb_data_t   rd_data,
    output dbgmon_trace_pkg::trig_cfg_t cfg,
    output logic                        stop_clear,
    output logic                        rd_en,
    output dbgmon_trace_pkg::buf_idx_t  rd_offset,
    output logic [2:0]                  rd_word
);

    localparam dbgmon_apb_pkg::apb_addr_t bp_base = `DBGMON_BP_BASE;
    localparam dbgmon_apb_pkg::apb_addr_t wp_base = `DBGMON_WP_BASE;
    localparam dbgmon_apb_pkg::apb_addr_t exc_adr = `DBGMON_EXC;
    localparam dbgmon_apb_pkg::apb_addr_t irq_adr = `DBGMON_IRQ;
    localparam dbgmon_apb_pkg::apb_addr_t dly_adr = `DBGMON_DELAY;
    localparam dbgmon_apb_pkg::apb_addr_t stp_adr = `DBGMON_STOP;

    logic                      setup;
    logic                      wr_setup;
    logic                      rd_setup;
    logic                      win_sel;
    logic                      bp_sel;
    logic                      wp_sel;
    logic [1:0]                m_idx;
    logic                      hi_word;
    logic [10:0]               word_adr;
    dbgmon_apb_pkg::apb_data_t wdata;
    dbgmon_apb_pkg::apb_data_t reg_rdata;
    dbgmon_apb_pkg::apb_data_t prdata_q;
    logic                      win_q;

    // ~~~~~~~~~~~~~~~~~~~~
    // address decode
    // ~~~~~~~~~~~~~~~~~~~~

    assign setup    = apb_req.psel && !apb_req.penable;
    assign wr_setup = setup && apb_req.pwrite;
    assign rd_setup = setup && !apb_req.pwrite;
    assign wdata    = apb_req.pwdata;

    assign win_sel  = !apb_req.paddr[12];
    assign bp_sel   = apb_req.paddr[12:5] == bp_base[12:5];
    assign wp_sel   = apb_req.paddr[12:5] == wp_base[12:5];
    assign m_idx    = apb_req.paddr[4:3];
    assign hi_word  = apb_req.paddr[2];
    assign word_adr = apb_req.paddr[12:2];

    // zero written to the stop register re-arms the trigger.
    assign stop_clear = wr_setup && word_adr == stp_adr[12:2] && !wdata[0];

    // trace window reads go straight to the buffer.
    assign rd_en     = rd_setup && win_sel;
    assign rd_offset = apb_req.paddr[11:5];
    assign rd_word   = apb_req.paddr[4:2];

    // ~~~~~~~~~~~~~~~~~~~~
    // configuration
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cfg <= '0;
        end else if (wr_setup) begin
            if (bp_sel && hi_word) begin
                {cfg.bp_en[m_idx], cfg.bp[m_idx][62:32]} <= wdata;
            end else if (bp_sel) begin
                cfg.bp[m_idx][31:0] <= wdata;
            end else if (wp_sel && hi_word) begin
                {cfg.wp_en[m_idx], cfg.wp[m_idx][62:32]} <= wdata;
            end else if (wp_sel) begin
                cfg.wp[m_idx][31:0] <= wdata;
            end else if (word_adr == exc_adr[12:2]) begin
                cfg.exc_mask <= wdata;
            end else if (word_adr == irq_adr[12:2]) begin
                cfg.irq_mask <= wdata;
            end else if (word_adr == dly_adr[12:2]) begin
                cfg.delay <= wdata[15:0];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // read path
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        reg_rdata = '0;
        if (bp_sel && hi_word) begin
            reg_rdata = {cfg.bp_en[m_idx], cfg.bp[m_idx][62:32]};
        end else if (bp_sel) begin
            reg_rdata = cfg.bp[m_idx][31:0];
        end else if (wp_sel && hi_word) begin
            reg_rdata = {cfg.wp_en[m_idx], cfg.wp[m_idx][62:32]};
        end else if (wp_sel) begin
            reg_rdata = cfg.wp[m_idx][31:0];
        end else if (word_adr == exc_adr[12:2]) begin
            reg_rdata = cfg.exc_mask;
        end else if (word_adr == irq_adr[12:2]) begin
            reg_rdata = cfg.irq_mask;
        end else if (word_adr == dly_adr[12:2]) begin
            reg_rdata = {16'd0, cfg.delay};
        end else if (word_adr == stp_adr[12:2]) begin
            reg_rdata = {31'd0, stopped};
        end
    end

    // captured at setup, shown during access.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prdata_q <= '0;
            win_q    <= 1'b0;
        end else if (rd_setup) begin
            prdata_q <= reg_rdata;
            win_q    <= win_sel;
        end
    end

    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = 1'b0;
    assign apb_rsp.prdata  = win_q ? rd_data : prdata_q;

    a_penable_psel: assert property (
        @(posedge clk) disable iff (!rstn) apb_req.penable |-> apb_req.psel
    ) else $error("penable without psel");

endmodule

//--- src/dbgmon_top.sv
module dbgmon_top (
    input  logic                         clk,
    input  logic                         rstn,
    input  dbgmon_apb_pkg::apb_req_t     apb_req,
    output dbgmon_apb_pkg::apb_rsp_t     apb_rsp,
    input  logic                         pkt_valid,
    input  dbgmon_trace_pkg::trace_pkt_t pkt,
    output logic                         irq
);

    dbgmon_trace_pkg::trig_cfg_t cfg;
    logic                        stop_clear;
    logic                        stopped;
    logic                        rd_en;
    dbgmon_trace_pkg::buf_idx_t  rd_offset;
    logic [2:0]                  rd_word;
    dbgmon_apb_pkg::apb_data_t   rd_data;

    dbgmon_reg_decode u_reg_decode (
        .clk        (clk),
        .rstn       (rstn),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .stopped    (stopped),
        .rd_data    (rd_data),
        .cfg        (cfg),
        .stop_clear (stop_clear),
        .rd_en      (rd_en),
        .rd_offset  (rd_offset),
        .rd_word    (rd_word)
    );

    dbgmon_trigger u_trigger (
        .clk        (clk),
        .rstn       (rstn),
        .cfg        (cfg),
        .pkt_valid  (pkt_valid),
        .pkt        (pkt),
        .stop_clear (stop_clear),
        .stopped    (stopped)
    );

    dbgmon_trace_buf u_trace_buf (
        .clk        (clk),
        .rstn       (rstn),
        .pkt_valid  (pkt_valid),
        .pkt        (pkt),
        .stopped    (stopped),
        .rd_en      (rd_en),
        .rd_offset  (rd_offset),
        .rd_word    (rd_word),
        .rd_data    (rd_data)
    );

    // interrupt stays high until software re-arms.
    assign irq = stopped;

endmodule

//--- src/dbgmon_trace_buf.sv
`include "dbgmon_defs.svh"

module dbgmon_trace_buf (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         pkt_valid,
    input  dbgmon_trace_pkg::trace_pkt_t pkt,
    input  logic                         stopped,
    input  logic                         rd_en,
    input  dbgmon_trace_pkg::buf_idx_t   rd_offset,
    input  logic [2:0]                   rd_word,
    output dbgmon_apb_pkg::apb_data_t    rd_data
);

    dbgmon_trace_pkg::trace_pkt_t mem [`DBGMON_DEPTH];
    dbgmon_trace_pkg::buf_idx_t   wr_ptr;
    dbgmon_trace_pkg::buf_idx_t   rd_idx;
    dbgmon_trace_pkg::trace_pkt_t rd_entry;
    logic                         wr_en;

    // ~~~~~~~~~~~~~~~~~~~~
    // write side
    // ~~~~~~~~~~~~~~~~~~~~

    // the buffer freezes once the trigger has stopped.
    assign wr_en = pkt_valid && !stopped;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= pkt;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // read side
    // ~~~~~~~~~~~~~~~~~~~~

    // offset 0 is the oldest slot, 127 the newest.
    // the index wraps modulo the depth.
    assign rd_idx   = wr_ptr + rd_offset;
    assign rd_entry = mem[rd_idx];

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= rd_entry[{rd_word, 5'd0} +: 32];
        end
    end

    a_frozen_ptr: assert property (
        @(posedge clk) disable iff (!rstn) stopped |=> wr_ptr == $past(wr_ptr)
    ) else $error("trace written while stopped");

endmodule

//--- src/dbgmon_trace_pkg.sv
`include "dbgmon_defs.svh"

package dbgmon_trace_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // retired event packet
    // ~~~~~~~~~~~~~~~~~~~~

    // load and store share bit 1 low.
    typedef enum logic [1:0] {
        pkt_load  = 2'd0,
        pkt_store = 2'd1,
        pkt_inst  = 2'd2,
        pkt_trap  = 2'd3
    } pkt_kind_t;

    // 256 bits, kind at the top and insn at the bottom.
    // for traps addr[4:0] is the cause and addr[31] flags an interrupt.
    typedef struct packed {
        pkt_kind_t   kind;
        logic [29:0] rsvd;
        logic [63:0] pc;
        logic [63:0] addr;
        logic [63:0] data;
        logic [31:0] insn;
    } trace_pkt_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // trigger setup
    // ~~~~~~~~~~~~~~~~~~~~

    // address with bit 0 dropped.
    typedef logic [62:0] match_addr_t;

    typedef struct packed {
        match_addr_t [`DBGMON_NUM_MATCH-1:0] bp;
        logic        [`DBGMON_NUM_MATCH-1:0] bp_en;
        match_addr_t [`DBGMON_NUM_MATCH-1:0] wp;
        logic        [`DBGMON_NUM_MATCH-1:0] wp_en;
        logic        [31:0]                  exc_mask;
        logic        [31:0]                  irq_mask;
        logic        [15:0]                  delay;
    } trig_cfg_t;

    typedef logic [`DBGMON_IDX_W-1:0] buf_idx_t;

    typedef enum logic [1:0] {
        trig_armed,
        trig_counting,
        trig_stopped
    } trig_state_t;

endpackage

//--- src/dbgmon_trigger.sv
`include "dbgmon_defs.svh"

module dbgmon_trigger (
    input  logic                        clk,
    input  logic                        rstn,
    input  dbgmon_trace_pkg::trig_cfg_t cfg,
    input  logic                        pkt_valid,
    input  dbgmon_trace_pkg::trace_pkt_t pkt,
    input  logic                        stop_clear,
    output logic                        stopped
);

    dbgmon_trace_pkg::trig_state_t state;
    logic [15:0]                   cnt;
    logic                          bp_hit;
    logic                          wp_hit;
    logic                          trap_hit;
    logic                          hit;
    logic                          is_trap;
    logic                          is_mem;
    logic [4:0]                    cause;

    // ~~~~~~~~~~~~~~~~~~~~
    // match logic
    // ~~~~~~~~~~~~~~~~~~~~

    assign is_trap = pkt.kind == dbgmon_trace_pkg::pkt_trap;
    assign is_mem  = pkt.kind == dbgmon_trace_pkg::pkt_load ||
                     pkt.kind == dbgmon_trace_pkg::pkt_store;
    assign cause   = pkt.addr[4:0];

    always_comb begin
        bp_hit = 1'b0;
        wp_hit = 1'b0;
        for (int i = 0; i < `DBGMON_NUM_MATCH; i++) begin
            if (cfg.bp_en[i] && cfg.bp[i] == pkt.pc[63:1]) begin
                bp_hit = 1'b1;
            end
            if (cfg.wp_en[i] && cfg.wp[i] == pkt.addr[63:1]) begin
                wp_hit = 1'b1;
            end
        end
    end

    // addr bit 31 picks the interrupt mask.
    assign trap_hit = is_trap && (pkt.addr[31] ? cfg.irq_mask[cause] : cfg.exc_mask[cause]);

    assign hit = (bp_hit && !is_trap) || (wp_hit && is_mem) || trap_hit;

    // ~~~~~~~~~~~~~~~~~~~~
    // stop fsm
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= dbgmon_trace_pkg::trig_armed;
            cnt   <= '0;
        end else if (stop_clear) begin
            state <= dbgmon_trace_pkg::trig_armed;
        end else begin
            case (state)
                dbgmon_trace_pkg::trig_armed: begin
                    if (pkt_valid && hit) begin
                        if (cfg.delay == 16'd0) begin
                            state <= dbgmon_trace_pkg::trig_stopped;
                        end else begin
                            state <= dbgmon_trace_pkg::trig_counting;
                            cnt   <= cfg.delay;
                        end
                    end
                end
                dbgmon_trace_pkg::trig_counting: begin
                    // the packet taken at count 1 is the last one recorded.
                    if (pkt_valid) begin
                        cnt <= cnt - 16'd1;
                        if (cnt == 16'd1) begin
                            state <= dbgmon_trace_pkg::trig_stopped;
                        end
                    end
                end
                dbgmon_trace_pkg::trig_stopped: begin
                    state <= dbgmon_trace_pkg::trig_stopped;
                end
                default: begin
                    state <= dbgmon_trace_pkg::trig_armed;
                end
            endcase
        end
    end

    assign stopped = state == dbgmon_trace_pkg::trig_stopped;

    a_stop_hold: assert property (
        @(posedge clk) disable iff (!rstn) $fell(stopped) |-> $past(stop_clear)
    ) else $error("stopped fell without stop_clear");

endmodule

//--- testbench/tb_dbgmon.sv
`include "dbgmon_defs.svh"

module tb_dbgmon;

    logic                         clk;
    logic                         rstn;
    dbgmon_apb_pkg::apb_req_t     apb_req;
    dbgmon_apb_pkg::apb_rsp_t     apb_rsp;
    logic                         pkt_valid;
    dbgmon_trace_pkg::trace_pkt_t pkt;
    logic                         irq;

    // mirror of the configuration and the expected trigger state.
    dbgmon_trace_pkg::match_addr_t m_bp [`DBGMON_NUM_MATCH];
    dbgmon_trace_pkg::match_addr_t m_wp [`DBGMON_NUM_MATCH];
    logic [`DBGMON_NUM_MATCH-1:0]  m_bp_en;
    logic [`DBGMON_NUM_MATCH-1:0]  m_wp_en;
    logic [31:0]                   m_exc;
    logic [31:0]                   m_irq;
    logic [15:0]                   m_delay;
    dbgmon_trace_pkg::trig_state_t m_state;
    logic [15:0]                   m_cnt;
    logic                          stop_wr;
    dbgmon_trace_pkg::trace_pkt_t  recorded [$];

    logic [31:0] lfsr;
    int          errors;
    int          tests_run;
    int          tests_failed;

    dbgmon_top u_dbgmon_top (
        .clk       (clk),
        .rstn      (rstn),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .pkt_valid (pkt_valid),
        .pkt       (pkt),
        .irq       (irq)
    );

    always #5 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic dbgmon_trace_pkg::trace_pkt_t rand_pkt(
        input dbgmon_trace_pkg::pkt_kind_t kind
    );
        dbgmon_trace_pkg::trace_pkt_t p;
        logic [63:0]                  t;
        p      = '0;
        p.kind = kind;
        p.pc   = rand_bits(64);
        p.addr = rand_bits(64);
        p.data = rand_bits(64);
        t      = rand_bits(32);
        p.insn = t[31:0];
        return p;
    endfunction

    // cause in addr[4:0], interrupt flag in addr[31].
    function automatic dbgmon_trace_pkg::trace_pkt_t trap_pkt(
        input logic intr, input logic [4:0] cause
    );
        dbgmon_trace_pkg::trace_pkt_t p;
        p      = rand_pkt(dbgmon_trace_pkg::pkt_trap);
        p.addr = {32'd0, intr, 26'd0, cause};
        return p;
    endfunction

    function automatic dbgmon_apb_pkg::apb_addr_t reg_addr(input int k);
        return `DBGMON_BP_BASE + dbgmon_apb_pkg::apb_addr_t'(k * 4);
    endfunction

    function automatic dbgmon_apb_pkg::apb_addr_t trace_addr(input int off, input int w);
        return dbgmon_apb_pkg::apb_addr_t'(off * 32 + w * 4);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic logic ref_hit(input dbgmon_trace_pkg::trace_pkt_t p);
        logic hit;
        logic is_trap;
        logic is_mem;
        is_trap = p.kind == dbgmon_trace_pkg::pkt_trap;
        is_mem  = p.kind == dbgmon_trace_pkg::pkt_load || p.kind == dbgmon_trace_pkg::pkt_store;
        hit     = 1'b0;
        for (int i = 0; i < `DBGMON_NUM_MATCH; i++) begin
            if (!is_trap && m_bp_en[i] && m_bp[i] == p.pc[63:1]) hit = 1'b1;
            if (is_mem && m_wp_en[i] && m_wp[i] == p.addr[63:1]) hit = 1'b1;
        end
        if (is_trap && !p.addr[31] && m_exc[p.addr[4:0]]) hit = 1'b1;
        if (is_trap && p.addr[31] && m_irq[p.addr[4:0]]) hit = 1'b1;
        return hit;
    endfunction

    // offset 127-j holds the j-th newest recorded packet.
    function automatic logic [31:0] ref_word(input int off, input int w);
        logic [255:0] bits;
        int           idx;
        idx  = recorded.size() - 1 - (127 - off);
        bits = recorded[idx];
        return bits[w*32 +: 32];
    endfunction

    function automatic void clear_mirror();
        for (int i = 0; i < `DBGMON_NUM_MATCH; i++) begin
            m_bp[i] = '0;
            m_wp[i] = '0;
        end
        m_bp_en = '0;
        m_wp_en = '0;
        m_exc   = '0;
        m_irq   = '0;
        m_delay = '0;
    endfunction

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            m_state = dbgmon_trace_pkg::trig_armed;
            m_cnt   = '0;
        end else begin
            stop_wr = apb_req.psel && !apb_req.penable && apb_req.pwrite &&
                      apb_req.paddr == `DBGMON_STOP && !apb_req.pwdata[0];
            if (pkt_valid && m_state != dbgmon_trace_pkg::trig_stopped) begin
                recorded.push_back(pkt);
            end
            if (stop_wr) begin
                m_state = dbgmon_trace_pkg::trig_armed;
            end else if (pkt_valid) begin
                if (m_state == dbgmon_trace_pkg::trig_armed && ref_hit(pkt)) begin
                    if (m_delay == 16'd0) begin
                        m_state = dbgmon_trace_pkg::trig_stopped;
                    end else begin
                        m_state = dbgmon_trace_pkg::trig_counting;
                        m_cnt   = m_delay;
                    end
                end else if (m_state == dbgmon_trace_pkg::trig_counting) begin
                    if (m_cnt == 16'd1) m_state = dbgmon_trace_pkg::trig_stopped;
                    m_cnt = m_cnt - 16'd1;
                end
            end
        end
    end

    // irq follows the expected stop state every cycle.
    always @(negedge clk) begin
        if (rstn) begin
            check_val("irq", {63'd0, m_state == dbgmon_trace_pkg::trig_stopped}, {63'd0, irq});
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // bus and packet tasks
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic apb_xfer(input logic wr, input dbgmon_apb_pkg::apb_addr_t addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        n = 0;
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= wr;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        while (!apb_rsp.pready && n < 16) begin
            @(negedge clk);
            n++;
        end
        if (!apb_rsp.pready) begin
            $display("APB transfer to %h never saw pready", addr);
            errors++;
        end
        check_val("pslverr", 64'd0, {63'd0, apb_rsp.pslverr});
        rdata = apb_rsp.prdata;
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic apb_write(input dbgmon_apb_pkg::apb_addr_t addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input dbgmon_apb_pkg::apb_addr_t addr, output logic [31:0] data);
        apb_xfer(1'b0, addr, 32'd0, data);
    endtask

    task automatic set_bp(input int i, input logic [63:0] a, input logic en);
        apb_write(`DBGMON_BP_BASE + dbgmon_apb_pkg::apb_addr_t'(8 * i), a[32:1]);
        apb_write(`DBGMON_BP_BASE + dbgmon_apb_pkg::apb_addr_t'(8 * i + 4), {en, a[63:33]});
        m_bp[i]    = a[63:1];
        m_bp_en[i] = en;
    endtask

    task automatic set_wp(input int i, input logic [63:0] a, input logic en);
        apb_write(`DBGMON_WP_BASE + dbgmon_apb_pkg::apb_addr_t'(8 * i), a[32:1]);
        apb_write(`DBGMON_WP_BASE + dbgmon_apb_pkg::apb_addr_t'(8 * i + 4), {en, a[63:33]});
        m_wp[i]    = a[63:1];
        m_wp_en[i] = en;
    endtask

    task automatic set_masks(input logic [31:0] exc, input logic [31:0] irqm);
        apb_write(`DBGMON_EXC, exc);
        apb_write(`DBGMON_IRQ, irqm);
        m_exc = exc;
        m_irq = irqm;
    endtask

    task automatic set_delay(input logic [15:0] d);
        apb_write(`DBGMON_DELAY, {16'd0, d});
        m_delay = d;
    endtask

    task automatic send_pkt(input dbgmon_trace_pkg::trace_pkt_t p);
        @(posedge clk);
        pkt_valid <= 1'b1;
        pkt       <= p;
    endtask

    task automatic pkt_idle();
        @(posedge clk);
        pkt_valid <= 1'b0;
    endtask

    task automatic send_random(input int n);
        logic [63:0] t;
        repeat (n) begin
            t = rand_bits(1);
            send_pkt(rand_pkt(t[0] ? dbgmon_trace_pkg::pkt_inst : dbgmon_trace_pkg::pkt_load));
        end
    endtask

    task automatic wait_irq(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!irq && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!irq) begin
            $display("irq did not rise within %0d cycles, time %0t", limit, $time);
            errors++;
        end
    endtask

    task automatic check_entry(input int off, input dbgmon_trace_pkg::trace_pkt_t p);
        logic [255:0] bits;
        logic [31:0]  d;
        bits = p;
        for (int w = 0; w < 8; w++) begin
            apb_read(trace_addr(off, w), d);
            check_val($sformatf("entry[%0d].word%0d", off, w), bits[w*32 +: 32], d);
        end
    endtask

    task automatic check_trace(input int lo, input int hi);
        logic [31:0] d;
        for (int off = lo; off <= hi; off++) begin
            if (127 - off < recorded.size()) begin
                for (int w = 0; w < 8; w++) begin
                    apb_read(trace_addr(off, w), d);
                    check_val($sformatf("trace[%0d].word%0d", off, w), ref_word(off, w), d);
                end
            end
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL, %0d errors", tests_run, name, errors - err_before);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // tests
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [63:0]                  t;
        logic [63:0]                  tgt;
        logic [31:0]                  d;
        logic [31:0]                  vals [19];
        dbgmon_trace_pkg::trace_pkt_t trig;
        int                           err0;

        clk          = 1'b0;
        rstn         = 1'b0;
        apb_req      = '0;
        pkt_valid    = 1'b0;
        pkt          = '0;
        lfsr         = 32'h09b9_1e47;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        clear_mirror();
        repeat (2) @(posedge clk);
        rstn <= 1'b1;

        // registers 0x1000 to 0x1048 are contiguous and delay is the last.
        err0 = errors;
        @(negedge clk);
        check_val("irq", 64'd0, {63'd0, irq});
        apb_read(`DBGMON_STOP, d);
        check_val("stop", 64'd0, d);
        for (int k = 0; k < 19; k++) begin
            t       = rand_bits(32);
            vals[k] = t[31:0];
            apb_write(reg_addr(k), vals[k]);
        end
        for (int k = 0; k < 19; k++) begin
            apb_read(reg_addr(k), d);
            t = (k == 18) ? {48'd0, vals[k][15:0]} : {32'd0, vals[k]};
            check_val($sformatf("reg[%h]", reg_addr(k)), t, d);
        end
        for (int k = 0; k < 19; k++) begin
            apb_write(reg_addr(k), 32'd0);
        end
        clear_mirror();
        end_test("register readback", err0);

        err0 = errors;
        tgt  = rand_bits(64);
        set_bp(1, tgt, 1'b1);
        send_random(10);
        trig    = rand_pkt(dbgmon_trace_pkg::pkt_inst);
        trig.pc = tgt;
        send_pkt(trig);
        pkt_idle();
        wait_irq(20);
        send_random(5);
        pkt_idle();
        check_entry(127, trig);
        check_trace(118, 127);
        end_test("breakpoint with delay 0", err0);

        err0 = errors;
        apb_write(`DBGMON_STOP, 32'd0);
        set_bp(1, 64'd0, 1'b0);
        set_delay(16'd3);
        tgt = rand_bits(64);
        set_wp(2, tgt, 1'b1);
        send_random(8);
        trig      = rand_pkt(dbgmon_trace_pkg::pkt_inst);
        trig.addr = tgt;
        send_pkt(trig);
        pkt_idle();
        @(negedge clk);
        check_val("irq", 64'd0, {63'd0, irq});
        trig      = rand_pkt(dbgmon_trace_pkg::pkt_store);
        trig.addr = tgt;
        send_pkt(trig);
        send_random(6);
        pkt_idle();
        wait_irq(20);
        check_entry(124, trig);
        check_trace(118, 127);
        end_test("watchpoint with delay 3", err0);

        // cause 11 is set only in the interrupt mask.
        err0 = errors;
        apb_write(`DBGMON_STOP, 32'd0);
        set_wp(2, 64'd0, 1'b0);
        set_delay(16'd0);
        set_masks(~((32'h1 << 7) | (32'h1 << 11)), 32'h1 << 11);
        send_random(4);
        send_pkt(trap_pkt(1'b0, 5'd7));
        send_pkt(trap_pkt(1'b0, 5'd11));
        send_pkt(trap_pkt(1'b1, 5'd7));
        pkt_idle();
        @(negedge clk);
        check_val("irq", 64'd0, {63'd0, irq});
        trig = trap_pkt(1'b1, 5'd11);
        send_pkt(trig);
        send_random(3);
        pkt_idle();
        wait_irq(20);
        check_entry(127, trig);
        check_trace(118, 127);
        end_test("trap masks", err0);

        err0 = errors;
        apb_write(`DBGMON_STOP, 32'd0);
        @(negedge clk);
        check_val("irq", 64'd0, {63'd0, irq});
        apb_read(`DBGMON_STOP, d);
        check_val("stop", 64'd0, d);
        set_masks(32'd0, 32'd0);
        set_delay(16'd2);
        tgt = rand_bits(64);
        set_bp(0, tgt, 1'b0);
        send_random(5);
        trig    = rand_pkt(dbgmon_trace_pkg::pkt_inst);
        trig.pc = tgt;
        send_pkt(trig);
        pkt_idle();
        @(negedge clk);
        check_val("irq", 64'd0, {63'd0, irq});
        tgt = rand_bits(64);
        set_bp(3, tgt, 1'b1);
        send_random(4);
        trig    = rand_pkt(dbgmon_trace_pkg::pkt_inst);
        trig.pc = tgt;
        send_pkt(trig);
        send_random(5);
        pkt_idle();
        wait_irq(20);
        apb_read(`DBGMON_STOP, d);
        check_val("stop", 64'd1, d);
        check_entry(125, trig);
        check_trace(100, 127);
        end_test("disabled matcher and re-arm", err0);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+src
src/dbgmon_apb_pkg.sv
src/dbgmon_trace_pkg.sv
src/dbgmon_reg_decode.sv
src/dbgmon_trigger.sv
src/dbgmon_trace_buf.sv
src/dbgmon_top.sv
testbench/tb_dbgmon.sv
